/* files.f */
+incdir+design
design/audio_pkg.sv
design/i2s_receiver.sv
design/sine_generator.sv
design/halfband_decimator.sv
design/pdm_modulator.sv
design/mic_array_top.sv
tests/clock_gen.sv
tests/audio_checker.sv
tests/mic_array_tb.sv

/* Makefile */
# Verilator flow for the microphone array testbench
VERILATOR ?= verilator
TOP       ?= mic_array_tb
RTL_TOP   ?= mic_array_top
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing
PASS_TEXT ?= TB PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(BUILD_DIR)/V$(TOP)
	$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* tests/mic_array_tb.sv */
`default_nettype none

module mic_array_tb;

  import audio_pkg::*;

  localparam int PHASES      = 10;
  localparam int WAIT_LIMIT  = 20000;

  logic        audio_clk;
  logic        rst;
  logic [2:0]  mic_data;
  logic [2:0]  i2s_clk;
  logic [2:0]  lrcl_clk;
  audio_ctrl_t ctrl;
  pcm_sample_t mic0_sample;
  pcm_sample_t mic1_sample;
  pcm_sample_t mic2_sample;
  pcm_sample_t decim_sample;
  logic        spk_left;
  logic        spk_right;
  logic        ok;

  logic [31:0] left_w [3];
  logic [31:0] right_w [3];
  int          pos [3];
  logic [2:0]  armed;
  logic [2:0]  prev_bclk;
  logic [2:0]  prev_lr;

  clock_gen clk_i (
    .audio_clk (audio_clk),
    .rst       (rst)
  );

  mic_array_top dut_i (
    .audio_clk    (audio_clk),
    .rst          (rst),
    .mic_data     (mic_data),
    .i2s_clk      (i2s_clk),
    .lrcl_clk     (lrcl_clk),
    .ctrl         (ctrl),
    .mic0_sample  (mic0_sample),
    .mic1_sample  (mic1_sample),
    .mic2_sample  (mic2_sample),
    .decim_sample (decim_sample),
    .spk_left     (spk_left),
    .spk_right    (spk_right)
  );

  audio_checker chk_i (
    .audio_clk    (audio_clk),
    .rst          (rst),
    .ctrl         (ctrl),
    .i2s_clk      (i2s_clk),
    .lrcl_clk     (lrcl_clk),
    .mic0_sample  (mic0_sample),
    .mic1_sample  (mic1_sample),
    .mic2_sample  (mic2_sample),
    .decim_sample (decim_sample),
    .spk_left     (spk_left),
    .spk_right    (spk_right)
  );

  // microphone models, new data after each falling bit clock
  always @(posedge audio_clk) begin
    #1;
    for (int n = 0; n < 3; n++) begin
      if (rst) begin
        armed[n] = 1'b1;
        pos[n]   = 0;
      end else if (armed[n] || (prev_lr[n] && !lrcl_clk[n])) begin
        left_w[n]  = $urandom;
        right_w[n] = $urandom;
        pos[n]     = 0;
        armed[n]   = 1'b0;
        // slot bit 0 is the delay bit, bits 1..16 the sample
        chk_i.push_expected(n, left_w[n][30:15]);
      end else if (!prev_lr[n] && lrcl_clk[n]) begin
        pos[n] = 0;
      end else if (prev_bclk[n] && !i2s_clk[n] && pos[n] < 31) begin
        pos[n]++;
      end
      mic_data[n] <= rst ? 1'b0 :
                     lrcl_clk[n] ? right_w[n][31-pos[n]] : left_w[n][31-pos[n]];
    end
    prev_bclk = rst ? 3'b0 : i2s_clk;
    prev_lr   = rst ? 3'b0 : lrcl_clk;
  end

  task automatic wait_reset(output logic done);
    int cnt;
    cnt  = 0;
    done = 1'b0;
    while (!done && cnt < 100) begin
      @(posedge audio_clk);
      #1;
      done = !rst;
      cnt++;
    end
    if (!done)
      $display("Timeout: reset never released");
  endtask

  task automatic wait_decim(input int pulses, output logic done);
    int cnt;
    int seen;
    cnt  = 0;
    seen = 0;
    while (seen < pulses && cnt < WAIT_LIMIT) begin
      @(posedge audio_clk);
      #1;
      if (decim_sample.valid)
        seen++;
      cnt++;
    end
    done = (seen >= pulses);
    if (!done)
      $display("Timeout: decimated samples stopped arriving");
  endtask

  initial begin
    void'($urandom(32'hdf996f81));
    mic_data = 3'b0;
    ctrl     = '0;
    ok       = 1'b1;
    wait_reset(ok);
    for (int p = 0; p < PHASES; p++) begin
      if (ok) begin
        ctrl = audio_ctrl_t'(5'($urandom));
        // first phases walk every source, tone b last
        if (p < 5) begin
          ctrl.src_sel  = 2'(p);
          ctrl.tone_sel = (p == 4);
        end
        // density phases keep both speakers on, later odd ones drop one
        if (p < 5 || p % 2 == 0) begin
          ctrl.spk_left_en  = 1'b1;
          ctrl.spk_right_en = 1'b1;
        end else if (p == 5) begin
          ctrl.spk_left_en = 1'b0;
        end else if (p == 7) begin
          ctrl.spk_right_en = 1'b0;
        end
        wait_decim(3, ok);
      end
    end
    $display("value errors %0d, other errors %0d", chk_i.value_errors, chk_i.other_errors);
    if (ok && chk_i.value_errors == 0 && chk_i.other_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tests/audio_checker.sv */
`default_nettype none

`include "mic_array_defines.svh"

module audio_checker (
  input wire logic                   audio_clk,
  input wire logic                   rst,
  input wire audio_pkg::audio_ctrl_t ctrl,
  input wire logic [2:0]             i2s_clk,
  input wire logic [2:0]             lrcl_clk,
  input wire audio_pkg::pcm_sample_t mic0_sample,
  input wire audio_pkg::pcm_sample_t mic1_sample,
  input wire audio_pkg::pcm_sample_t mic2_sample,
  input wire audio_pkg::pcm_sample_t decim_sample,
  input wire logic                   spk_left,
  input wire logic                   spk_right
);

  import audio_pkg::*;

  int                 value_errors = 0;
  int                 other_errors = 0;
  logic signed [15:0] exp0[$];
  logic signed [15:0] exp1[$];
  logic signed [15:0] exp2[$];
  pcm_sample_t        mics [3];
  logic [2:0]         prev_bclk;
  logic [2:0]         prev_lr;
  int                 half_cnt [3];
  int                 fall_cnt [3];
  int                 pulse_cnt [3];
  logic signed [15:0] hist [4];
  logic               odd;
  logic               dec_pend;
  logic signed [15:0] dec_exp;
  logic signed [15:0] mic0_hold;
  logic signed [15:0] dec_hold;
  logic signed [15:0] lvl_d1;
  logic signed [15:0] lvl_d2;
  logic signed [15:0] seg_level;
  longint             seg_n;
  longint             seg_ones;
  int                 cyc;
  logic               started = 1'b0;
  logic               rst_q = 1'b1;

  assign mics[0] = mic0_sample;
  assign mics[1] = mic1_sample;
  assign mics[2] = mic2_sample;

  function void push_expected(input int n, input logic signed [15:0] v);
    case (n)
      0:       exp0.push_back(v);
      1:       exp1.push_back(v);
      default: exp2.push_back(v);
    endcase
  endfunction

  task automatic report_value(input string name, input longint e, input longint a);
    value_errors++;
    $display("** Error [%s] expected %0d actual %0d at %0t", name, e, a, $time);
  endtask

  task automatic report_problem(input string msg);
    other_errors++;
    $display("Problem: %s at %0t", msg, $time);
  endtask

  // 64-step sine, step s has round(127*sin(2*pi*(s+0.5)/64))
  function automatic int table_amp(input logic [5:0] s);
    real v;
    v = 127.0 * $sin(2.0 * 3.141592653589793 * (real'(s) + 0.5) / 64.0);
    return $rtoi(v >= 0.0 ? v + 0.5 : v - 0.5);
  endfunction

  // tone register after edge k holds the table entry of the phase after edge k-1
  function automatic logic signed [15:0] tone_level(input logic [31:0] incr, input int k);
    int          t;
    logic [31:0] ph;
    t  = (k >= 2) ? (k - 2) / `TRIGGER_PERIOD + 1 : 0;
    ph = incr * 32'(t);
    return 16'(table_amp(ph[31:26]) * 256);
  endfunction

  task automatic close_segment();
    longint off;
    off = longint'(seg_level) + 32768;
    if (seg_n > 0) begin
      if (seg_ones * 65536 - seg_n * off > 65536 || seg_n * off - seg_ones * 65536 > 65536)
        report_value("pdm_density", seg_n * off / 65536, seg_ones);
    end
    seg_n    = 0;
    seg_ones = 0;
  endtask

  task automatic check_capture(input int n);
    logic signed [15:0] e;
    int                 depth;
    depth = (n == 0) ? exp0.size() : (n == 1) ? exp1.size() : exp2.size();
    pulse_cnt[n]++;
    if (depth == 0) begin
      report_problem($sformatf("mic%0d valid with no word sent", n));
    end else begin
      e = (n == 0) ? exp0.pop_front() : (n == 1) ? exp1.pop_front() : exp2.pop_front();
      if (mics[n].data !== e)
        report_value($sformatf("mic%0d_capture", n), e, mics[n].data);
      if (n == 0) begin
        mic0_hold = e;
        hist[3] = hist[2];
        hist[2] = hist[1];
        hist[1] = hist[0];
        hist[0] = e;
        odd = ~odd;
        if (!odd) begin
          dec_pend = 1'b1;
          dec_exp  = 16'((int'(hist[0]) + hist[1] + hist[2] + hist[3]) >>> 2);
        end
      end
    end
  endtask

  always @(posedge audio_clk) started <= 1'b1;

  // reset as the DUT sampled it on the last rising edge
  always @(posedge audio_clk) rst_q <= rst;

  always @(negedge audio_clk) begin
    logic signed [15:0] nxt;
    logic               bit_dec;
    if (rst_q) begin
      if (started && (i2s_clk !== 3'b0 || lrcl_clk !== 3'b0))
        report_problem("bit or word clock not low in reset");
      prev_bclk = '0;
      prev_lr   = '0;
      for (int n = 0; n < 3; n++) begin
        half_cnt[n]  = 0;
        fall_cnt[n]  = 0;
        pulse_cnt[n] = 0;
        hist[n]      = '0;
      end
      hist[3]   = '0;
      odd       = 1'b0;
      dec_pend  = 1'b0;
      mic0_hold = '0;
      dec_hold  = '0;
      lvl_d1    = '0;
      lvl_d2    = '0;
      seg_level = '0;
      seg_n     = 0;
      seg_ones  = 0;
      cyc       = 0;
    end else begin
      cyc++;
      for (int n = 0; n < 3; n++) begin
        half_cnt[n]++;
        if (i2s_clk[n] != prev_bclk[n]) begin
          if (half_cnt[n] != `I2S_HALF_PERIOD)
            report_value($sformatf("i2s%0d_half_period", n), `I2S_HALF_PERIOD, half_cnt[n]);
          half_cnt[n] = 0;
        end
        if (prev_bclk[n] && !i2s_clk[n])
          fall_cnt[n]++;
        if (lrcl_clk[n] != prev_lr[n]) begin
          if (!(prev_bclk[n] && !i2s_clk[n]))
            report_problem($sformatf("lrcl%0d moved off a falling bit clock", n));
          if (fall_cnt[n] != `I2S_SLOT_BITS)
            report_value($sformatf("lrcl%0d_slot_bits", n), `I2S_SLOT_BITS, fall_cnt[n]);
          fall_cnt[n] = 0;
          if (!lrcl_clk[n]) begin
            if (pulse_cnt[n] != 1)
              report_value($sformatf("mic%0d_pulses_per_frame", n), 1, pulse_cnt[n]);
            pulse_cnt[n] = 0;
          end
        end
      end
      // registered source mux as it will look after the next edge
      case (ctrl.src_sel)
        2'd0:    nxt = tone_level(ctrl.tone_sel ? `TONE_B_INCR : `TONE_A_INCR, cyc);
        2'd1:    nxt = mic0_hold;
        2'd2:    nxt = dec_hold;
        default: nxt = '0;
      endcase
      if (dec_pend) begin
        if (!decim_sample.valid) begin
          report_problem("decimated sample missing one cycle after input");
        end else if (decim_sample.data !== dec_exp) begin
          report_value("decim_average", dec_exp, decim_sample.data);
        end
        dec_hold = dec_exp;
        dec_pend = 1'b0;
      end else if (decim_sample.valid) begin
        report_problem("decimated sample valid on an odd input");
      end
      for (int n = 0; n < 3; n++) begin
        if (mics[n].valid)
          check_capture(n);
      end
      if (!ctrl.spk_left_en && spk_left)
        report_problem("left speaker active while disabled");
      if (!ctrl.spk_right_en && spk_right)
        report_problem("right speaker active while disabled");
      bit_dec = ctrl.spk_left_en && ctrl.spk_right_en;
      if (bit_dec && spk_left !== spk_right)
        report_value("speaker_match", spk_left, spk_right);
      // speaker bit now visible came from the level two edges back
      if (bit_dec) begin
        if (lvl_d2 != seg_level) begin
          close_segment();
          seg_level = lvl_d2;
        end
        seg_n++;
        seg_ones += spk_left;
      end else begin
        close_segment();
      end
      lvl_d2 = lvl_d1;
      lvl_d1 = nxt;
      prev_bclk = i2s_clk;
      prev_lr   = lrcl_clk;
    end
  end

endmodule

`default_nettype wire

/* tests/clock_gen.sv */
`default_nettype none

module clock_gen (
  output logic audio_clk,
  output logic rst
);

  initial begin
    audio_clk = 1'b0;
    forever #20 audio_clk = ~audio_clk;
  end

  // reset held for 8 rising edges
  initial begin
    rst = 1'b1;
    repeat (8) @(posedge audio_clk);
    #1 rst = 1'b0;
  end

endmodule

`default_nettype wire

/* design/mic_array_top.sv */
`default_nettype none

`include "mic_array_defines.svh"

module mic_array_top (
  input  wire logic                   audio_clk,
  input  wire logic                   rst,
  input  wire logic [2:0]             mic_data,
  output logic [2:0]                  i2s_clk,
  output logic [2:0]                  lrcl_clk,
  input  wire audio_pkg::audio_ctrl_t ctrl,
  output audio_pkg::pcm_sample_t      mic0_sample,
  output audio_pkg::pcm_sample_t      mic1_sample,
  output audio_pkg::pcm_sample_t      mic2_sample,
  output audio_pkg::pcm_sample_t      decim_sample,
  output logic                        spk_left,
  output logic                        spk_right
);

  import audio_pkg::*;

  localparam int TRIG_W = $clog2(`TRIGGER_PERIOD);
  localparam int PAD_W  = `SAMPLE_WIDTH - `TONE_WIDTH;

  logic [TRIG_W-1:0]               trig_cnt;
  logic                            sample_trigger;
  logic signed [`TONE_WIDTH-1:0]   tone_a;
  logic signed [`TONE_WIDTH-1:0]   tone_b;
  logic signed [`TONE_WIDTH-1:0]   tone_amp;
  logic signed [`SAMPLE_WIDTH-1:0] mic0_level;
  logic signed [`SAMPLE_WIDTH-1:0] decim_level;
  logic signed [`SAMPLE_WIDTH-1:0] pdm_level;
  logic                            pdm_bit;

  // free-running tone step counter
  always_ff @(posedge audio_clk) begin
    if (rst) begin
      trig_cnt <= '0;
    end else begin
      trig_cnt <= trig_cnt + 1'b1;
    end
  end

  assign sample_trigger = (trig_cnt == '0);

  i2s_receiver mic0_rx_i (
    .audio_clk (audio_clk),
    .rst       (rst),
    .mic_data  (mic_data[0]),
    .i2s_clk   (i2s_clk[0]),
    .lrcl_clk  (lrcl_clk[0]),
    .sample    (mic0_sample)
  );

  i2s_receiver mic1_rx_i (
    .audio_clk (audio_clk),
    .rst       (rst),
    .mic_data  (mic_data[1]),
    .i2s_clk   (i2s_clk[1]),
    .lrcl_clk  (lrcl_clk[1]),
    .sample    (mic1_sample)
  );

  i2s_receiver mic2_rx_i (
    .audio_clk (audio_clk),
    .rst       (rst),
    .mic_data  (mic_data[2]),
    .i2s_clk   (i2s_clk[2]),
    .lrcl_clk  (lrcl_clk[2]),
    .sample    (mic2_sample)
  );

  // anti-alias and 2:1 decimate on mic 0
  halfband_decimator decim_i (
    .audio_clk  (audio_clk),
    .rst        (rst),
    .sample_in  (mic0_sample),
    .sample_out (decim_sample)
  );

  sine_generator #(.PHASE_INCR(`TONE_A_INCR)) tone_a_i (
    .audio_clk (audio_clk),
    .rst       (rst),
    .step      (sample_trigger),
    .amp       (tone_a)
  );

  sine_generator #(.PHASE_INCR(`TONE_B_INCR)) tone_b_i (
    .audio_clk (audio_clk),
    .rst       (rst),
    .step      (sample_trigger),
    .amp       (tone_b)
  );

  assign tone_amp = ctrl.tone_sel ? tone_b : tone_a;

  always_ff @(posedge audio_clk) begin
    if (rst) begin
      mic0_level  <= '0;
      decim_level <= '0;
      pdm_level   <= '0;
    end else begin
      if (mic0_sample.valid) begin
        mic0_level <= mic0_sample.data;
      end
      if (decim_sample.valid) begin
        decim_level <= decim_sample.data;
      end
      // tone goes into the upper byte
      case (ctrl.src_sel)
        SRC_TONE:  pdm_level <= {tone_amp, {PAD_W{1'b0}}};
        SRC_MIC0:  pdm_level <= mic0_level;
        SRC_DECIM: pdm_level <= decim_level;
        SRC_MUTE:  pdm_level <= '0;
      endcase
    end
  end

  pdm_modulator pdm_i (
    .audio_clk (audio_clk),
    .rst       (rst),
    .level     (pdm_level),
    .pdm       (pdm_bit)
  );

  // same stream on both pins, each with its own enable
  assign spk_left  = pdm_bit & ctrl.spk_left_en;
  assign spk_right = pdm_bit & ctrl.spk_right_en;

endmodule

`default_nettype wire

/* design/pdm_modulator.sv */
`default_nettype none

`include "mic_array_defines.svh"

module pdm_modulator (
  input  wire logic                        audio_clk,
  input  wire logic                        rst,
  input  wire logic signed [`SAMPLE_WIDTH-1:0] level,
  output logic                             pdm
);

  logic [`SAMPLE_WIDTH-1:0] acc;
  logic [`SAMPLE_WIDTH-1:0] offset_level;
  logic [`SAMPLE_WIDTH:0]   acc_next;

  // flip the sign bit to get offset binary
  assign offset_level = {~level[`SAMPLE_WIDTH-1], level[`SAMPLE_WIDTH-2:0]};
  assign acc_next     = {1'b0, acc} + {1'b0, offset_level};

  // carry out is the one-bit stream
  always_ff @(posedge audio_clk) begin
    if (rst) begin
      acc <= '0;
      pdm <= 1'b0;
    end else begin
      acc <= acc_next[`SAMPLE_WIDTH-1:0];
      pdm <= acc_next[`SAMPLE_WIDTH];
    end
  end

endmodule

`default_nettype wire

/* design/halfband_decimator.sv */
`default_nettype none

`include "mic_array_defines.svh"

module halfband_decimator (
  input  wire logic                   audio_clk,
  input  wire logic                   rst,
  input  wire audio_pkg::pcm_sample_t sample_in,
  output audio_pkg::pcm_sample_t      sample_out
);

  localparam int TAPS  = 4;
  // two extra bits hold the sum of four samples
  localparam int SUM_W = `SAMPLE_WIDTH + $clog2(TAPS);

  logic signed [`SAMPLE_WIDTH-1:0] hist [TAPS-1];
  logic signed [`SAMPLE_WIDTH-1:0] new_sample;
  logic signed [SUM_W-1:0]         sum;
  logic                            odd_q;

  assign new_sample = sample_in.data;

  // newest sample plus the three before it
  always_comb begin
    sum = SUM_W'(new_sample);
    for (int i = 0; i < TAPS - 1; i++) begin
      sum = sum + SUM_W'(hist[i]);
    end
  end

  always_ff @(posedge audio_clk) begin
    if (rst) begin
      for (int i = 0; i < TAPS - 1; i++) begin
        hist[i] <= '0;
      end
      odd_q      <= 1'b0;
      sample_out <= '0;
    end else begin
      sample_out.valid <= 1'b0;
      if (sample_in.valid) begin
        hist[0] <= new_sample;
        for (int i = 1; i < TAPS - 1; i++) begin
          hist[i] <= hist[i-1];
        end
        odd_q <= ~odd_q;
        // keep every second average
        if (odd_q) begin
          sample_out.data  <= sum[SUM_W-1:SUM_W-`SAMPLE_WIDTH];
          sample_out.valid <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* design/sine_generator.sv */
`default_nettype none

`include "mic_array_defines.svh"

module sine_generator #(
  parameter logic [31:0] PHASE_INCR = `TONE_A_INCR
) (
  input  wire logic                     audio_clk,
  input  wire logic                     rst,
  input  wire logic                     step,
  output logic signed [`TONE_WIDTH-1:0] amp
);

  localparam int MAG_W = `TONE_WIDTH - 1;

  logic [31:0]      phase;
  logic [1:0]       quad;
  logic [3:0]       idx;
  logic [3:0]       tbl_idx;
  logic [MAG_W-1:0] mag;

  // first quarter of round(127*sin(2*pi*(k+0.5)/64))
  function automatic logic [MAG_W-1:0] quarter_sin(input logic [3:0] i);
    case (i)
      4'd0:    quarter_sin = MAG_W'(6);
      4'd1:    quarter_sin = MAG_W'(19);
      4'd2:    quarter_sin = MAG_W'(31);
      4'd3:    quarter_sin = MAG_W'(43);
      4'd4:    quarter_sin = MAG_W'(54);
      4'd5:    quarter_sin = MAG_W'(65);
      4'd6:    quarter_sin = MAG_W'(76);
      4'd7:    quarter_sin = MAG_W'(85);
      4'd8:    quarter_sin = MAG_W'(94);
      4'd9:    quarter_sin = MAG_W'(102);
      4'd10:   quarter_sin = MAG_W'(109);
      4'd11:   quarter_sin = MAG_W'(115);
      4'd12:   quarter_sin = MAG_W'(120);
      4'd13:   quarter_sin = MAG_W'(123);
      4'd14:   quarter_sin = MAG_W'(126);
      default: quarter_sin = MAG_W'(127);
    endcase
  endfunction

  assign quad = phase[31:30];
  assign idx  = phase[29:26];

  // odd quadrants read the table backwards
  assign tbl_idx = quad[0] ? ~idx : idx;
  assign mag     = quarter_sin(tbl_idx);

  always_ff @(posedge audio_clk) begin
    if (rst) begin
      phase <= '0;
      amp   <= '0;
    end else begin
      if (step) begin
        phase <= phase + PHASE_INCR;
      end
      // second half of the cycle is negative
      amp <= quad[1] ? -$signed({1'b0, mag}) : $signed({1'b0, mag});
    end
  end

endmodule

`default_nettype wire

/* design/i2s_receiver.sv */
`default_nettype none

`include "mic_array_defines.svh"

module i2s_receiver (
  input  wire logic             audio_clk,
  input  wire logic             rst,
  input  wire logic             mic_data,
  output logic                  i2s_clk,
  output logic                  lrcl_clk,
  output audio_pkg::pcm_sample_t sample
);

  localparam int HALF_W = $clog2(`I2S_HALF_PERIOD);
  localparam int BIT_W  = $clog2(`I2S_SLOT_BITS);

  logic [HALF_W-1:0]        half_cnt;
  logic [BIT_W-1:0]         bit_cnt;
  logic [`SAMPLE_WIDTH-1:0] shift_q;
  logic                     half_done;
  logic                     bclk_rise;
  logic                     bclk_fall;
  logic                     in_sample;
  logic                     last_bit;

  assign half_done = (half_cnt == HALF_W'(`I2S_HALF_PERIOD - 1));
  assign bclk_rise = half_done && !i2s_clk;
  assign bclk_fall = half_done && i2s_clk;

  // bit 0 is the i2s delay bit, bits 1..16 carry the left sample
  assign in_sample = !lrcl_clk && (bit_cnt != '0) &&
                     (bit_cnt <= BIT_W'(`SAMPLE_WIDTH));
  assign last_bit  = (bit_cnt == BIT_W'(`SAMPLE_WIDTH));

  always_ff @(posedge audio_clk) begin
    if (rst) begin
      half_cnt <= '0;
      bit_cnt  <= '0;
      i2s_clk  <= 1'b0;
      lrcl_clk <= 1'b0;
      sample   <= '0;
    end else begin
      sample.valid <= 1'b0;
      half_cnt     <= half_done ? '0 : half_cnt + 1'b1;
      if (half_done) begin
        i2s_clk <= ~i2s_clk;
      end
      // slot boundary sits on a falling bit clock edge
      if (bclk_fall) begin
        if (bit_cnt == BIT_W'(`I2S_SLOT_BITS - 1)) begin
          bit_cnt  <= '0;
          lrcl_clk <= ~lrcl_clk;
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
      if (bclk_rise && in_sample && last_bit) begin
        sample.data  <= {shift_q[`SAMPLE_WIDTH-2:0], mic_data};
        sample.valid <= 1'b1;
      end
    end
  end

  // msb first deserializer
  always_ff @(posedge audio_clk) begin
    if (bclk_rise && in_sample) begin
      shift_q <= {shift_q[`SAMPLE_WIDTH-2:0], mic_data};
    end
  end

endmodule

`default_nettype wire

/* design/audio_pkg.sv */
`default_nettype none

`include "mic_array_defines.svh"

package audio_pkg;

  // one pcm word with its strobe
  typedef struct packed {
    logic                             valid;
    logic signed [`SAMPLE_WIDTH-1:0]  data;
  } pcm_sample_t;

  // mode switches
  typedef struct packed {
    logic       spk_left_en;
    logic       spk_right_en;
    logic       tone_sel;
    logic [1:0] src_sel;
  } audio_ctrl_t;

  // src_sel codes
  localparam logic [1:0] SRC_TONE  = 2'd0;
  localparam logic [1:0] SRC_MIC0  = 2'd1;
  localparam logic [1:0] SRC_DECIM = 2'd2;
  localparam logic [1:0] SRC_MUTE  = 2'd3;

endpackage

`default_nettype wire

/* design/mic_array_defines.svh */
`ifndef MIC_ARRAY_DEFINES_SVH
`define MIC_ARRAY_DEFINES_SVH

// pcm sample and tone amplitude widths
`define SAMPLE_WIDTH 16
`define TONE_WIDTH 8

// i2s bit clock, audio_clk cycles per half period
`define I2S_HALF_PERIOD 16
// bit clocks per word-select half
`define I2S_SLOT_BITS 32

// audio_clk cycles between tone steps
`define TRIGGER_PERIOD 4096

// phase increments, roughly 750 Hz and 880 Hz at the trigger rate
`define TONE_A_INCR 32'h0800_0000
`define TONE_B_INCR 32'h0962_FC96

`endif
